//--- testdata_pmod_seq.hex
// record: word count, program words, expected pmod[3:0], minimum cycles
// a word count of 0 ends the list
// writes to each index, then halt
6 10000001 10020001 10030001 10030000 10010001 00000000 7 17
// write, wait 40 cycles, write, halt
4 10020000 20000028 10030001 00000000 b 35
// jump over two writes
6 10010000 30000004 10000000 10030000 10020001 00000000 d 0e
// unknown opcode halts before the last write
4 10030000 f0000000 10000000 00000000 5 07
0

//--- filelist.f
pmod_seq_pkg.sv
tcm_host_port.sv
seq_fsm.sv
core_timer.sv
wb_reg_bank.sv
pmod_seq_top.sv
pmod_seq_checker.sv
tb_pmod_seq.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the pmod sequencer testbench with verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_pmod_seq -f filelist.f -o sim_pmod_seq

out=$(./obj_dir/sim_pmod_seq 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
else
    exit 1
fi

//--- tb_pmod_seq.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pmod_seq;

    logic                  clk;
    logic                  reset;
    pmod_seq_pkg::wb_req_t host_req;
    pmod_seq_pkg::wb_rsp_t host_rsp;
    logic [7:0]            pmod;

    logic [31:0] tdata [64];  // test records.
    int          cycle_cnt;
    int          beat_ref;    // cycles since reset release.
    int          timeout_limit;
    int          err_cnt;
    int          chk_cnt;
    logic        track;
    logic        track_prev;
    int          changes;
    int          last_change;
    int          min_gap;
    logic [3:0]  prev_low;

    pmod_seq_top #(
        .HEARTBEAT_BITS (8)
    ) u_pmod_seq_top (
        .clk      (clk),
        .reset    (reset),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .pmod     (pmod)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        beat_ref  <= reset ? 0 : beat_ref + 1; // zero in the first cycle after release.
    end

    always @(posedge clk) begin
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("timeout, the run did not finish within %0d cycles", timeout_limit);
            end_run(1'b1);
        end
    end

    // spacing of changes on the low pins while a program runs.
    always @(negedge clk) begin
        if (track && !track_prev) begin
            changes = 0;
            min_gap = 32'h7fff_ffff;
        end else if (track && pmod[3:0] !== prev_low) begin
            if (changes > 0 && cycle_cnt - last_change < min_gap) begin
                min_gap = cycle_cnt - last_change;
            end
            changes++;
            last_change = cycle_cnt;
        end
        track_prev = track;
        prev_low   = pmod[3:0];
    end

    function automatic logic [31:0] word_at(input int p);
        return tdata[p[5:0]];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt++;
        assert (got === exp) else begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pins(input logic [3:0] exp_low);
        @(negedge clk);
        check_value("pmod[3:0]", 32'(pmod[3:0]), 32'(exp_low));
        check_value("pmod[7:4]", 32'(pmod[7:4]), 32'(beat_ref[7:4])); // count mod 256.
    endtask

    // one wishbone classic transfer on the host port.
    task automatic bus_cycle(input logic we, input logic [8:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int waited;
        waited = 0;
        rdat   = 'x;
        @(posedge clk);
        host_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdat};
        do begin
            @(negedge clk);
            waited++;
        end while (!host_rsp.ack && waited < 20);
        if (host_rsp.ack) begin
            rdat = host_rsp.dat_r;
        end else begin
            err_cnt++;
            $display("host bus gave no ack within 20 cycles for address %0d", adr);
        end
        @(posedge clk);
        host_req <= '0;
    endtask

    task automatic end_run(input logic timed_out);
        $display("checks %0d, errors %0d, timeout %0d", chk_cnt, err_cnt, timed_out);
        if (err_cnt == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    initial begin
        int          pos;
        int          n;
        int          test_no;
        int          need_gap;
        int          min_cyc;
        int          t_start;
        int          sum_min;
        int          words;
        logic [31:0] instr;
        logic [31:0] rdat;
        logic [31:0] status;

        host_req <= '0;
        reset    <= 1'b1;
        track    = 1'b0;
        $readmemh("testdata_pmod_seq.hex", tdata);

        while (word_at(pos) != 0) begin
            n        = int'(word_at(pos));
            sum_min += int'(word_at(pos + n + 2));
            words   += n;
            test_no++;
            pos     += n + 3;
        end
        // per test minimum plus slack, and bus transfers at worst case.
        timeout_limit = sum_min + 200 * test_no + 25 * (2 * words + test_no + 2) + 20;

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        chk_cnt++;
        assert (test_no > 0) else begin
            err_cnt++;
            $display("no test records were read from the data file");
        end
        check_pins(4'h0);
        bus_cycle(1'b0, pmod_seq_pkg::CTRL_ADDR, '0, rdat);
        check_value("ctrl status", rdat, 32'h0000_0001); // halted, pc 0.

        pos     = 0;
        test_no = 0;
        while (word_at(pos) != 0) begin
            n        = int'(word_at(pos));
            min_cyc  = int'(word_at(pos + n + 2));
            need_gap = 0;
            for (int i = 0; i < n; i++) begin
                instr = word_at(pos + 1 + i);
                bus_cycle(1'b1, 9'(i), instr, rdat);
                if (instr[31:28] == pmod_seq_pkg::OP_WAIT) begin
                    need_gap = int'(instr[15:0]);
                end
            end
            for (int i = 0; i < n; i++) begin
                bus_cycle(1'b0, 9'(i), '0, rdat);
                check_value("program word", rdat, word_at(pos + 1 + i));
            end

            track = 1'b1;
            bus_cycle(1'b1, pmod_seq_pkg::CTRL_ADDR, 32'h1, rdat); // start.
            t_start = cycle_cnt;
            status  = '0;
            while (status[0] !== 1'b1 && cycle_cnt - t_start < min_cyc + 200) begin
                bus_cycle(1'b0, pmod_seq_pkg::CTRL_ADDR, '0, status);
            end
            track = 1'b0;

            chk_cnt++;
            assert (status[0] === 1'b1) else begin
                err_cnt++;
                $display("test %0d: sequencer still running after %0d cycles",
                         test_no, cycle_cnt - t_start);
            end
            chk_cnt++;
            assert (cycle_cnt - t_start >= min_cyc) else begin
                err_cnt++;
                $display("test %0d: program halted after %0d cycles, sooner than %0d",
                         test_no, cycle_cnt - t_start, min_cyc);
            end
            if (need_gap > 0) begin
                chk_cnt++;
                assert (changes >= 2 && min_gap >= need_gap) else begin
                    err_cnt++;
                    $display("test %0d: pmod[3:0] changed %0d cycles apart across a wait of %0d",
                             test_no, min_gap, need_gap);
                end
            end
            check_pins(4'(word_at(pos + n + 1)));
            pos += n + 3;
            test_no++;
        end
        end_run(1'b0);
    end

endmodule

`default_nettype wire

//--- pmod_seq_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pmod_seq_checker (
    input var logic                  clk,
    input var logic                  reset,
    input var logic                  start,
    input var logic                  halted,
    input var pmod_seq_pkg::wb_req_t reg_req,
    input var pmod_seq_pkg::wb_rsp_t reg_rsp
);

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
        reg_rsp.ack |=> !reg_rsp.ack)
        else $error("register bus ack held for more than one cycle");

    // master keeps the strobe up until the slave answers.
    stb_until_ack: assert property (@(posedge clk) disable iff (reset)
        (reg_req.stb && !reg_rsp.ack) |=> reg_req.stb)
        else $error("register bus stb dropped before ack");

    cyc_low_after_reset: assert property (@(posedge clk)
        reset |=> !reg_req.cyc)
        else $error("register bus cyc high after reset");

    halted_needs_start: assert property (@(posedge clk) disable iff (reset)
        (halted && !start) |=> halted)
        else $error("sequencer left halt without a start pulse");

endmodule

bind seq_fsm pmod_seq_checker u_pmod_seq_checker (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .halted  (halted),
    .reg_req (reg_req),
    .reg_rsp (reg_rsp)
);

`default_nettype wire

//--- pmod_seq_top.sv
`timescale 1ns/1ps
`default_nettype none

module pmod_seq_top #(
    parameter int HEARTBEAT_BITS = pmod_seq_pkg::HEARTBEAT_BITS_DEFAULT
) (
    input  var logic                   clk,
    input  var logic                   reset,
    input  var pmod_seq_pkg::wb_req_t  host_req,
    output var pmod_seq_pkg::wb_rsp_t  host_rsp,
    output var logic [7:0]             pmod
);

    logic                                   start;
    logic                                   halted;
    logic [pmod_seq_pkg::TCM_ADDR_BITS-1:0] pc;
    logic [pmod_seq_pkg::TCM_ADDR_BITS-1:0] fetch_addr;
    pmod_seq_pkg::instr_t                   fetch_data;
    pmod_seq_pkg::wb_req_t                  reg_req;
    pmod_seq_pkg::wb_rsp_t                  reg_rsp;
    logic                                   wait_load;
    logic [pmod_seq_pkg::WAIT_BITS-1:0]     wait_count;
    logic                                   wait_done;
    logic [pmod_seq_pkg::NUM_OUT_REGS-1:0]  out_bits;
    logic [3:0]                             heartbeat;

    tcm_host_port u_tcm_host_port (
        .clk        (clk),
        .reset      (reset),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .start      (start),
        .halted     (halted),
        .pc         (pc),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

    seq_fsm u_seq_fsm (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .halted     (halted),
        .pc         (pc),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .reg_req    (reg_req),
        .reg_rsp    (reg_rsp),
        .wait_load  (wait_load),
        .wait_count (wait_count),
        .wait_done  (wait_done)
    );

    core_timer #(
        .HEARTBEAT_BITS (HEARTBEAT_BITS)
    ) u_core_timer (
        .clk        (clk),
        .reset      (reset),
        .wait_load  (wait_load),
        .wait_count (wait_count),
        .wait_done  (wait_done),
        .heartbeat  (heartbeat)
    );

    wb_reg_bank u_wb_reg_bank (
        .clk        (clk),
        .reset      (reset),
        .reg_req    (reg_req),
        .reg_rsp    (reg_rsp),
        .out_bits   (out_bits)
    );

    assign pmod = {heartbeat, out_bits}; // heartbeat on the upper pins.

endmodule

`default_nettype wire

//--- wb_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module wb_reg_bank (
    input  var logic                                   clk,
    input  var logic                                   reset,
    input  var pmod_seq_pkg::wb_req_t                  reg_req,
    output var pmod_seq_pkg::wb_rsp_t                  reg_rsp,
    output var logic [pmod_seq_pkg::NUM_OUT_REGS-1:0]  out_bits
);

    logic                                  req_valid;
    logic                                  accept;
    logic                                  served;
    logic                                  ack;
    logic [pmod_seq_pkg::REG_IDX_BITS-1:0] idx;
    logic [pmod_seq_pkg::WB_DATA_BITS-1:0] dat_r;

    assign req_valid = reg_req.cyc && reg_req.stb;
    assign accept    = req_valid && !ack && !served;
    assign idx       = reg_req.adr[pmod_seq_pkg::REG_IDX_BITS-1:0];

    // bit updates on the same edge that raises ack.
    always_ff @(posedge clk) begin
        if (reset) begin
            ack      <= 1'b0;
            served   <= 1'b0;
            out_bits <= '0;
        end else begin
            ack    <= accept;
            served <= req_valid && (served || ack);
            if (accept && reg_req.we) begin
                out_bits[idx] <= reg_req.dat_w[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dat_r <= {{(pmod_seq_pkg::WB_DATA_BITS - 1){1'b0}}, out_bits[idx]};
        end
    end

    assign reg_rsp = '{ack: ack, dat_r: dat_r};

endmodule

`default_nettype wire

//--- core_timer.sv
`timescale 1ns/1ps
`default_nettype none

module core_timer #(
    parameter int HEARTBEAT_BITS = pmod_seq_pkg::HEARTBEAT_BITS_DEFAULT
) (
    input  var logic                                clk,
    input  var logic                                reset,
    input  var logic                                wait_load,
    input  var logic [pmod_seq_pkg::WAIT_BITS-1:0]  wait_count,
    output var logic                                wait_done,
    output var logic [3:0]                          heartbeat
);

    logic [HEARTBEAT_BITS-1:0]          beat_cnt;
    logic [pmod_seq_pkg::WAIT_BITS-1:0] wait_cnt;

    // free running, zero in the first cycle out of reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            beat_cnt <= '0;
        end else begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (wait_load) begin
            wait_cnt <= wait_count;
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1; // stops at zero.
        end
    end

    assign wait_done = (wait_cnt == '0);
    assign heartbeat = beat_cnt[HEARTBEAT_BITS-1 -: 4]; // top nibble.

endmodule

`default_nettype wire

//--- seq_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module seq_fsm (
    input  var logic                                    clk,
    input  var logic                                    reset,
    input  var logic                                    start,
    output var logic                                    halted,
    output var logic [pmod_seq_pkg::TCM_ADDR_BITS-1:0]  pc,
    output var logic [pmod_seq_pkg::TCM_ADDR_BITS-1:0]  fetch_addr,
    input  var pmod_seq_pkg::instr_t                    fetch_data,
    output var pmod_seq_pkg::wb_req_t                   reg_req,
    input  var pmod_seq_pkg::wb_rsp_t                   reg_rsp,
    output var logic                                    wait_load,
    output var logic [pmod_seq_pkg::WAIT_BITS-1:0]      wait_count,
    input  var logic                                    wait_done
);

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        BUS,
        WAIT,
        HALT
    } state_e;

    state_e                                state;
    logic                                  req_active;
    logic [pmod_seq_pkg::WB_ADDR_BITS-1:0] req_adr;
    logic [pmod_seq_pkg::WB_DATA_BITS-1:0] req_dat;

    assign fetch_addr = pc; // word is latched by the ram during FETCH.

    // timer is loaded while the WAIT word is being decoded.
    assign wait_load  = (state == DECODE) && (fetch_data.opcode == pmod_seq_pkg::OP_WAIT);
    assign wait_count = fetch_data.arg;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            halted     <= 1'b1;
            pc         <= '0;
            req_active <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        pc     <= '0;
                        halted <= 1'b0;
                        state  <= FETCH;
                    end
                end
                FETCH: begin
                    state <= DECODE;
                end
                DECODE: begin
                    case (fetch_data.opcode)
                        pmod_seq_pkg::OP_WRITE: begin
                            req_active <= 1'b1;
                            state      <= BUS;
                        end
                        pmod_seq_pkg::OP_WAIT: begin
                            state <= WAIT;
                        end
                        pmod_seq_pkg::OP_JUMP: begin
                            pc    <= fetch_data.arg[pmod_seq_pkg::TCM_ADDR_BITS-1:0];
                            state <= FETCH;
                        end
                        default: begin
                            state <= HALT; // halt and unknown opcodes.
                        end
                    endcase
                end
                BUS: begin
                    if (reg_rsp.ack) begin
                        req_active <= 1'b0;
                        pc         <= pc + 1'b1; // wraps at the end of memory.
                        state      <= FETCH;
                    end
                end
                WAIT: begin
                    if (wait_done) begin
                        pc    <= pc + 1'b1;
                        state <= FETCH;
                    end
                end
                HALT: begin
                    halted <= 1'b1;
                    state  <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // bus payload, captured on decode.
    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            req_adr <= {{(pmod_seq_pkg::WB_ADDR_BITS - pmod_seq_pkg::REG_IDX_BITS){1'b0}},
                        fetch_data.reg_idx};
            req_dat <= {{(pmod_seq_pkg::WB_DATA_BITS - 1){1'b0}}, fetch_data.arg[0]};
        end
    end

    // single master, so cyc and stb move together.
    assign reg_req = '{
        cyc:   req_active,
        stb:   req_active,
        we:    1'b1,
        adr:   req_adr,
        dat_w: req_dat
    };

endmodule

`default_nettype wire

//--- tcm_host_port.sv
`timescale 1ns/1ps
`default_nettype none

module tcm_host_port (
    input  var logic                                    clk,
    input  var logic                                    reset,
    input  var pmod_seq_pkg::wb_req_t                   host_req,
    output var pmod_seq_pkg::wb_rsp_t                   host_rsp,
    output var logic                                    start,
    input  var logic                                    halted,
    input  var logic [pmod_seq_pkg::TCM_ADDR_BITS-1:0]  pc,
    input  var logic [pmod_seq_pkg::TCM_ADDR_BITS-1:0]  fetch_addr,
    output var pmod_seq_pkg::instr_t                    fetch_data
);

    logic [pmod_seq_pkg::WB_DATA_BITS-1:0] mem [pmod_seq_pkg::TCM_WORDS];

    logic                                   req_valid;
    logic                                   accept;
    logic                                   served;
    logic                                   ack;
    logic                                   is_mem;
    logic                                   is_ctrl;
    logic [pmod_seq_pkg::TCM_ADDR_BITS-1:0] mem_idx;
    logic [pmod_seq_pkg::WB_DATA_BITS-1:0]  ctrl_word;
    logic [pmod_seq_pkg::WB_DATA_BITS-1:0]  dat_r;

    assign req_valid = host_req.cyc && host_req.stb;
    assign accept    = req_valid && !ack && !served; // one ack per strobe.
    assign mem_idx   = host_req.adr[pmod_seq_pkg::TCM_ADDR_BITS-1:0];
    assign is_mem    = (host_req.adr[pmod_seq_pkg::WB_ADDR_BITS-1:pmod_seq_pkg::TCM_ADDR_BITS] == '0);
    assign is_ctrl   = (host_req.adr == pmod_seq_pkg::CTRL_ADDR);

    // status view of the control register.
    always_comb begin
        ctrl_word = '0;
        ctrl_word[0] = halted;
        ctrl_word[8 +: pmod_seq_pkg::TCM_ADDR_BITS] = pc;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack    <= 1'b0;
            served <= 1'b0;
            start  <= 1'b0;
        end else begin
            ack    <= accept;
            served <= req_valid && (served || ack); // held until stb drops.
            start  <= accept && host_req.we && is_ctrl && host_req.dat_w[0] && halted;
        end
    end

    // host port of the program ram.
    always_ff @(posedge clk) begin
        if (accept && host_req.we && is_mem) begin
            mem[mem_idx] <= host_req.dat_w;
        end
        if (accept) begin
            if (is_ctrl) begin
                dat_r <= ctrl_word;
            end else if (is_mem) begin
                dat_r <= mem[mem_idx];
            end else begin
                dat_r <= '0; // unmapped.
            end
        end
    end

    // sequencer read port, one cycle latency.
    always_ff @(posedge clk) begin
        fetch_data <= pmod_seq_pkg::instr_t'(mem[fetch_addr]);
    end

    assign host_rsp = '{ack: ack, dat_r: dat_r};

endmodule

`default_nettype wire

//--- pmod_seq_pkg.sv
`default_nettype none

package pmod_seq_pkg;

    localparam int TCM_WORDS              = 64;
    localparam int TCM_ADDR_BITS          = 6;
    localparam int NUM_OUT_REGS           = 4;
    localparam int REG_IDX_BITS           = $clog2(NUM_OUT_REGS);
    localparam int WB_ADDR_BITS           = 9;
    localparam int WB_DATA_BITS           = 32;
    localparam int WAIT_BITS              = 16;
    localparam int HEARTBEAT_BITS_DEFAULT = 28;

    localparam logic [WB_ADDR_BITS-1:0] CTRL_ADDR = 9'd256;

    // wishbone classic request, master to slave.
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [WB_ADDR_BITS-1:0] adr;
        logic [WB_DATA_BITS-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic                    ack;
        logic [WB_DATA_BITS-1:0] dat_r;
    } wb_rsp_t;

    typedef enum logic [3:0] {
        OP_HALT  = 4'd0,
        OP_WRITE = 4'd1,
        OP_WAIT  = 4'd2,
        OP_JUMP  = 4'd3
    } opcode_e;

    // 32-bit program word, opcode in the top nibble.
    typedef struct packed {
        opcode_e                 opcode;
        logic [9:0]              spare;
        logic [REG_IDX_BITS-1:0] reg_idx;
        logic [WAIT_BITS-1:0]    arg;     // value, count or target.
    } instr_t;

endpackage

`default_nettype wire
